// File: bench/executeCases.mem
// columns: instruction word, expected result, expected zero, expected overflow (hex)
// cases run in order, registers carry over from one line to the next
3C011234 12340000 0 0  // lui r1 0x1234
34215678 12345678 0 0  // ori r1 r1, forwarded
3C027FFF 7FFF0000 0 0  // lui r2 0x7fff
3442FFFF 7FFFFFFF 0 0  // ori r2 r2
20430001 80000000 0 1  // addi r3 r2 1, overflow
00602021 00000000 0 0  // addu r4 r3 r0, r3 never written
00422820 FFFFFFFE 0 1  // add r5 r2 r2, overflow
00A03021 00000000 0 0  // addu r6 r5 r0
3C078000 80000000 0 0  // lui r7 0x8000
00E14022 6DCBA988 0 1  // sub r8 r7 r1, overflow
01004821 00000000 0 0  // addu r9 r8 r0
20EAFFFF 7FFFFFFF 0 1  // addi r10 r7 -1, overflow
00215822 00000000 1 0  // sub r11 r1 r1
00426023 00000000 1 0  // subu r12 r2 r2
00226821 92345677 0 0  // addu r13 r1 r2
01A17023 7FFFFFFF 0 0  // subu r14 r13 r1, forwarded
25CE0001 80000000 0 0  // addiu r14 r14 1, forwarded
01C0782A 00000001 0 0  // slt r15 r14 r0
01C0802B 00000000 0 0  // sltu r16 r14 r0
29D10000 00000001 0 0  // slti r17 r14 0
2C128000 00000001 0 0  // sltiu r18 r0 0x8000
28138000 00000000 0 0  // slti r19 r0 0x8000
01A1A024 12345670 0 0  // and r20 r13 r1
31B5F0F0 00005070 0 0  // andi r21 r13 0xf0f0
0020B027 EDCBA987 0 0  // nor r22 r1 r0
0001B900 23456780 0 0  // sll r23 r1 4
000DC202 00923456 0 0  // srl r24 r13 8
0020C808 12345678 0 0  // jr r1 with rd 25
0320D021 00000000 0 0  // addu r26 r25 r0
FC211234 00000000 0 0  // undefined opcode
0022183F 00000000 0 0  // undefined function code
24000055 00000055 0 0  // addiu r0 r0 0x55
0000D821 00000000 0 0  // addu r27 r0 r0

// File: bench/executeCoreTb.sv
module executeCoreTb import mipsPkg::*;
();

	// one line of the case file, plus its position
	typedef struct packed
	{
		logic [15:0] idx;
		instrWord instr;
		logic [31:0] result;
		logic zero;
		logic overflow;
	} caseT;

	logic clk;
	logic rstN;
	instrWord instr;
	logic instrValid;
	logic [31:0] result;
	logic zero;
	logic overflow;
	logic resultValid;

	caseT cases[$];
	// issued, not yet checked
	caseT expected[$];
	logic [31:0] lfsrState = 32'd84721;
	int valueErrors = 0;
	int protocolErrors = 0;
	int assertErrors = 0;
	int cycleCount = 0;
	int cycleLimit = 0;

	executeCore i_executeCore
	(
		.clk(clk),
		.rstN(rstN),
		.instr(instr),
		.instrValid(instrValid),
		.result(result),
		.zero(zero),
		.overflow(overflow),
		.resultValid(resultValid)
	);

	// 20 unit period
	always #10 clk = ~clk;

	// galois lfsr, right shifting, taps 32 22 2 1
	function automatic logic randomBit();
		logic b;
		b = lfsrState[0];
		lfsrState = lfsrState[0] ? (lfsrState >> 1) ^ 32'h80200003 : lfsrState >> 1;
		return b;
	endfunction

	task automatic checkWord(input string name, input logic [31:0] expVal,
		input logic [31:0] actVal);
		if (actVal !== expVal)
		begin
			valueErrors++;
			$display("CHECK FAILED %s expected %h actual %h", name, expVal, actVal);
		end
	endtask

	task automatic checkFlag(input string name, input logic expVal, input logic actVal);
		if (actVal !== expVal)
		begin
			valueErrors++;
			$display("CHECK FAILED %s expected %b actual %b", name, expVal, actVal);
		end
	endtask

	// lines that do not parse as four fields are comments
	task automatic readCases();
		int fd;
		int n;
		string line;
		caseT c;
		logic [31:0] iw;
		logic [31:0] rv;
		logic z;
		logic o;
		fd = $fopen("bench/executeCases.mem", "r");
		if (fd == 0)
		begin
			$display("could not open bench/executeCases.mem");
		end
		else
		begin
			while (!$feof(fd))
			begin
				line = "";
				if ($fgets(line, fd) != 0)
				begin
					n = $sscanf(line, "%h %h %h %h", iw, rv, z, o);
					if (n == 4)
					begin
						c.idx = 16'(cases.size());
						c.instr = iw;
						c.result = rv;
						c.zero = z;
						c.overflow = o;
						cases.push_back(c);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// outputs change on rising edges, sampled here on falling ones
	task automatic checkOutputs();
		caseT e;
		string name;
		if (expected.size() != 0)
		begin
			e = expected.pop_front();
			if (resultValid !== 1'b1)
			begin
				protocolErrors++;
				$display("case %0d: no resultValid one cycle after the instruction", e.idx);
			end
			else
			begin
				name = $sformatf("case %0d instr %h", e.idx, e.instr);
				checkWord({name, " result"}, e.result, result);
				checkFlag({name, " zero"}, e.zero, zero);
				checkFlag({name, " overflow"}, e.overflow, overflow);
			end
		end
		else if (resultValid !== 1'b0)
		begin
			protocolErrors++;
			$display("resultValid high with no instruction issued");
		end
	endtask

	// run limit, from the case count
	always @(posedge clk)
	begin
		cycleCount++;
		if (cycleLimit != 0 && cycleCount >= cycleLimit)
		begin
			$display("timeout after %0d cycles, results did not drain", cycleLimit);
			$display("Simulation FAILED");
			$finish;
		end
	end

	initial
	begin
		logic gapA;
		logic gapB;
		clk = 1'b0;
		rstN = 1'b0;
		instr = '0;
		instrValid = 1'b0;
		readCases();
		cycleLimit = 16 + 2 * cases.size() + 50;

		repeat (16) @(negedge clk);
		rstN = 1'b1;

		if (cases.size() == 0)
		begin
			protocolErrors++;
			$display("no test cases read from bench/executeCases.mem");
		end
		else
		begin
			foreach (cases[i])
			begin
				// about one case in four gets an idle cycle first
				gapA = randomBit();
				gapB = randomBit();
				if (gapA && gapB)
				begin
					@(negedge clk);
					checkOutputs();
					instrValid = 1'b0;
				end
				@(negedge clk);
				checkOutputs();
				instr = cases[i].instr;
				instrValid = 1'b1;
				expected.push_back(cases[i]);
			end
			@(negedge clk);
			checkOutputs();
			instrValid = 1'b0;
			// drain, then one quiet cycle
			while (expected.size() != 0)
			begin
				@(negedge clk);
				checkOutputs();
			end
			@(negedge clk);
			checkOutputs();
		end

		assertErrors = i_executeCore.i_executeCoreProperties.assertFails;
		$display("errors: %0d value, %0d protocol, %0d assertion",
			valueErrors, protocolErrors, assertErrors);
		if (valueErrors + protocolErrors + assertErrors == 0)
		begin
			$display("Simulation PASSED");
		end
		else
		begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

// File: bench/executeCore_properties.sv
module executeCoreProperties import mipsPkg::*;
(
	input logic clk,
	input logic rstN,
	input logic instrValid,
	input logic resultValid,
	input logic zero,
	input logic overflow,
	input pendT pend
);

	// failures seen so far, read by the testbench
	int assertFails = 0;

	// every accepted instruction gives a result strobe one cycle later
	validFollows: assert property (@(posedge clk) disable iff (!rstN)
		instrValid |=> resultValid)
	else
	begin
		assertFails++;
		$error("resultValid missing one cycle after instrValid");
	end

	// and no strobe without an instruction before it
	validOnlyAfter: assert property (@(posedge clk) disable iff (!rstN)
		!instrValid |=> !resultValid)
	else
	begin
		assertFails++;
		$error("resultValid high with no instruction in the cycle before");
	end

	// zero only on a clean difference
	flagsExclusive: assert property (@(posedge clk) disable iff (!rstN)
		!(zero && overflow))
	else
	begin
		assertFails++;
		$error("zero and overflow both high");
	end

	// register zero never gets a writeback
	noZeroWrite: assert property (@(posedge clk) disable iff (!rstN)
		(pend.valid && pend.write) |-> pend.dest != 5'd0)
	else
	begin
		assertFails++;
		$error("writeback requested for register zero");
	end

endmodule

bind executeCore executeCoreProperties i_executeCoreProperties
(
	.clk(clk),
	.rstN(rstN),
	.instrValid(instrValid),
	.resultValid(resultValid),
	.zero(zero),
	.overflow(overflow),
	.pend(pend)
);

// File: design/alu.sv
module alu import mipsPkg::*;
(
	input logic clk,
	input logic rstN,
	input logic instrValid,
	input ctrlT ctrl,
	input logic [31:0] opA,
	input logic [31:0] opB,
	input logic [4:0] shamt,
	input logic [4:0] dest,
	output logic [31:0] result,
	output logic zero,
	output logic overflow,
	output pendT pend
);

	logic [31:0] sum;
	logic [31:0] diff;
	logic addOvf;
	logic subOvf;
	logic [31:0] nextResult;
	logic nextZero;
	logic nextOverflow;
	logic nextWrite;

	// shared adder and subtractor
	assign sum = opA + opB;
	assign diff = opA - opB;

	// same-sign operands, sum sign flipped
	assign addOvf = (opA[31] == opB[31]) && (sum[31] != opA[31]);
	// differing signs, difference sign not matching a
	assign subOvf = (opA[31] != opB[31]) && (diff[31] != opA[31]);

	// flags come from the value being registered
	always_comb
	begin
		nextResult = '0;
		nextZero = 1'b0;
		nextOverflow = 1'b0;

		case (ctrl.aluOp)
			aluLui: nextResult = opB << 16;
			aluOr: nextResult = opA | opB;
			aluAnd: nextResult = opA & opB;
			aluNor: nextResult = ~(opA | opB);
			aluAddu: nextResult = sum;
			aluAdd:
			begin
				nextResult = sum;
				nextOverflow = addOvf;
			end
			aluSubu:
			begin
				nextResult = diff;
				nextZero = (diff == 32'h0);
			end
			aluSub:
			begin
				nextResult = diff;
				nextOverflow = subOvf;
				// zero is only reported on a valid difference
				nextZero = (diff == 32'h0) && !subOvf;
			end
			aluSll: nextResult = opB << shamt;
			aluSrl: nextResult = opB >> shamt;
			aluSlt: nextResult = {31'h0, $signed(opA) < $signed(opB)};
			aluSltu: nextResult = {31'h0, opA < opB};
			// jr, hand rs straight through
			aluPass: nextResult = opA;
			// nop and unknown codes give zero
			default: nextResult = '0;
		endcase
	end

	// overflow kills the write, as does a zero destination
	assign nextWrite = ctrl.regWrite && !nextOverflow && dest != 5'd0;

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			result <= '0;
			zero <= 1'b0;
			overflow <= 1'b0;
			pend <= '0;
		end
		else if (instrValid)
		begin
			result <= nextResult;
			zero <= nextZero;
			overflow <= nextOverflow;
			pend.valid <= 1'b1;
			pend.dest <= dest;
			pend.write <= nextWrite;
		end
		else
		begin
			// outputs hold, only the strobe and write drop
			pend.valid <= 1'b0;
			pend.write <= 1'b0;
		end
	end

endmodule

// File: design/aluControl.sv
module aluControl import mipsPkg::*;
(
	input instrWord instr,
	output ctrlT ctrl
);

	always_comb
	begin
		// anything not listed below stays a nop with no writeback
		ctrl.aluOp = aluNop;
		ctrl.extMode = extNone;
		ctrl.useImm = 1'b0;
		ctrl.destRt = 1'b0;
		ctrl.regWrite = 1'b0;
		ctrl.isShift = 1'b0;

		case (instr.rType.opcode)
			opRType:
			begin
				// register ops write rd
				ctrl.regWrite = 1'b1;
				case (instr.rType.funct)
					fnAdd: ctrl.aluOp = aluAdd;
					fnAddu: ctrl.aluOp = aluAddu;
					fnSub: ctrl.aluOp = aluSub;
					fnSubu: ctrl.aluOp = aluSubu;
					fnAnd: ctrl.aluOp = aluAnd;
					fnOr: ctrl.aluOp = aluOr;
					fnNor: ctrl.aluOp = aluNor;
					fnSlt: ctrl.aluOp = aluSlt;
					fnSltu: ctrl.aluOp = aluSltu;
					fnSll:
					begin
						ctrl.aluOp = aluSll;
						ctrl.isShift = 1'b1;
					end
					fnSrl:
					begin
						ctrl.aluOp = aluSrl;
						ctrl.isShift = 1'b1;
					end
					// jr only passes rs, nothing written
					fnJr:
					begin
						ctrl.aluOp = aluPass;
						ctrl.regWrite = 1'b0;
					end
					default: ctrl.regWrite = 1'b0;
				endcase
			end
			default:
			begin
				// immediate ops write rt
				ctrl.useImm = 1'b1;
				ctrl.destRt = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.extMode = extSign;
				case (instr.iType.opcode)
					opAddi: ctrl.aluOp = aluAdd;
					opAddiu: ctrl.aluOp = aluAddu;
					opSlti: ctrl.aluOp = aluSlt;
					// sign-extended, compared unsigned
					opSltiu: ctrl.aluOp = aluSltu;
					opAndi:
					begin
						ctrl.aluOp = aluAnd;
						ctrl.extMode = extZero;
					end
					opOri:
					begin
						ctrl.aluOp = aluOr;
						ctrl.extMode = extZero;
					end
					opLui:
					begin
						ctrl.aluOp = aluLui;
						ctrl.extMode = extZero;
					end
					default:
					begin
						// undefined opcode
						ctrl.useImm = 1'b0;
						ctrl.destRt = 1'b0;
						ctrl.regWrite = 1'b0;
						ctrl.extMode = extNone;
					end
				endcase
			end
		endcase
	end

endmodule

// File: design/executeCore.sv
module executeCore import mipsPkg::*;
(
	input logic clk,
	input logic rstN,
	input instrWord instr,
	input logic instrValid,
	output logic [31:0] result,
	output logic zero,
	output logic overflow,
	output logic resultValid
);

	ctrlT ctrl;
	pendT pend;
	logic [4:0] readAddrA;
	logic [4:0] readAddrB;
	logic [31:0] readDataA;
	logic [31:0] readDataB;
	logic [31:0] opA;
	logic [31:0] opB;
	logic [4:0] shamt;
	logic [4:0] dest;

	// decode
	aluControl i_aluControl
	(
		.instr(instr),
		.ctrl(ctrl)
	);

	// writeback port is fed straight from the alu output stage
	registerFile i_registerFile
	(
		.clk(clk),
		.rstN(rstN),
		.readAddrA(readAddrA),
		.readAddrB(readAddrB),
		.readDataA(readDataA),
		.readDataB(readDataB),
		.writeEn(pend.valid & pend.write),
		.writeAddr(pend.dest),
		.writeData(result)
	);

	// operand build and forwarding
	operandSelect i_operandSelect
	(
		.instr(instr),
		.ctrl(ctrl),
		.pend(pend),
		.pendResult(result),
		.readAddrA(readAddrA),
		.readAddrB(readAddrB),
		.readDataA(readDataA),
		.readDataB(readDataB),
		.opA(opA),
		.opB(opB),
		.shamt(shamt),
		.dest(dest)
	);

	// registered execute
	alu i_alu
	(
		.clk(clk),
		.rstN(rstN),
		.instrValid(instrValid),
		.ctrl(ctrl),
		.opA(opA),
		.opB(opB),
		.shamt(shamt),
		.dest(dest),
		.result(result),
		.zero(zero),
		.overflow(overflow),
		.pend(pend)
	);

	// result strobe is the pending-valid bit
	assign resultValid = pend.valid;

endmodule

// File: design/mipsPkg.sv
package mipsPkg;

	// register-format view of an instruction
	typedef struct packed
	{
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rTypeT;

	// immediate-format view, same 32 bits
	typedef struct packed
	{
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [15:0] imm;
	} iTypeT;

	// one word, decoded either way depending on opcode
	typedef union packed
	{
		rTypeT rType;
		iTypeT iType;
	} instrWord;

	// alu operation codes
	typedef enum logic [3:0]
	{
		aluNop = 4'h0,
		aluLui = 4'h1,
		aluAddu = 4'h2,
		aluOr = 4'h3,
		aluAdd = 4'h4,
		aluAnd = 4'h5,
		aluSubu = 4'h6,
		aluSub = 4'h7,
		aluSll = 4'h8,
		aluSrl = 4'h9,
		aluSlt = 4'ha,
		aluSltu = 4'hb,
		aluNor = 4'hc,
		aluPass = 4'hd
	} aluOpT;

	// how the 16-bit immediate becomes 32 bits
	typedef enum logic [1:0]
	{
		extSign = 2'd0,
		extZero = 2'd1,
		extNone = 2'd2
	} extModeT;

	// decoded control for one instruction
	typedef struct packed
	{
		aluOpT aluOp;
		extModeT extMode;
		logic useImm;
		// write to rt rather than rd
		logic destRt;
		logic regWrite;
		logic isShift;
	} ctrlT;

	// instruction sitting in the alu output register
	typedef struct packed
	{
		logic valid;
		logic [4:0] dest;
		logic write;
	} pendT;

	// opcodes
	localparam logic [5:0] opRType = 6'h00;
	localparam logic [5:0] opAddi = 6'h08;
	localparam logic [5:0] opAddiu = 6'h09;
	localparam logic [5:0] opSlti = 6'h0a;
	localparam logic [5:0] opSltiu = 6'h0b;
	localparam logic [5:0] opAndi = 6'h0c;
	localparam logic [5:0] opOri = 6'h0d;
	localparam logic [5:0] opLui = 6'h0f;

	// function codes for opRType
	localparam logic [5:0] fnSll = 6'h00;
	localparam logic [5:0] fnSrl = 6'h02;
	localparam logic [5:0] fnJr = 6'h08;
	localparam logic [5:0] fnAdd = 6'h20;
	localparam logic [5:0] fnAddu = 6'h21;
	localparam logic [5:0] fnSub = 6'h22;
	localparam logic [5:0] fnSubu = 6'h23;
	localparam logic [5:0] fnAnd = 6'h24;
	localparam logic [5:0] fnOr = 6'h25;
	localparam logic [5:0] fnNor = 6'h27;
	localparam logic [5:0] fnSlt = 6'h2a;
	localparam logic [5:0] fnSltu = 6'h2b;

endpackage

// File: design/operandSelect.sv
module operandSelect import mipsPkg::*;
(
	input instrWord instr,
	input ctrlT ctrl,
	input pendT pend,
	input logic [31:0] pendResult,
	output logic [4:0] readAddrA,
	output logic [4:0] readAddrB,
	input logic [31:0] readDataA,
	input logic [31:0] readDataB,
	output logic [31:0] opA,
	output logic [31:0] opB,
	output logic [4:0] shamt,
	output logic [4:0] dest
);

	logic fwdOk;
	logic fwdA;
	logic fwdB;
	logic [31:0] rsVal;
	logic [31:0] rtVal;
	logic [31:0] immExt;

	// rs and rt sit at the same place in both formats
	assign readAddrA = instr.rType.rs;
	assign readAddrB = instr.rType.rt;

	// pending result will be written next edge, so bypass it
	assign fwdOk = pend.valid && pend.write && pend.dest != 5'd0;
	assign fwdA = fwdOk && pend.dest == readAddrA;
	assign fwdB = fwdOk && pend.dest == readAddrB;

	assign rsVal = fwdA ? pendResult : readDataA;
	assign rtVal = fwdB ? pendResult : readDataB;

	// immediate extension
	always_comb
	begin
		case (ctrl.extMode)
			extSign: immExt = {{16{instr.iType.imm[15]}}, instr.iType.imm};
			extZero: immExt = {16'h0000, instr.iType.imm};
			default: immExt = '0;
		endcase
	end

	// shifts only use rt, rs field is don't-care
	assign opA = ctrl.isShift ? 32'h0 : rsVal;
	// rt stays in opB for shifts and all register ops
	assign opB = ctrl.useImm ? immExt : rtVal;

	// shift amount only meaningful for sll and srl
	assign shamt = ctrl.isShift ? instr.rType.shamt : 5'd0;

	// immediate ops target rt, register ops target rd
	assign dest = ctrl.destRt ? instr.iType.rt : instr.rType.rd;

endmodule

// File: design/registerFile.sv
module registerFile
(
	input logic clk,
	input logic rstN,
	input logic [4:0] readAddrA,
	input logic [4:0] readAddrB,
	output logic [31:0] readDataA,
	output logic [31:0] readDataB,
	input logic writeEn,
	input logic [4:0] writeAddr,
	input logic [31:0] writeData
);

	// 32 general registers
	logic [31:0] regs [32];

	// single write port
	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			// architectural state starts at zero
			for (int i = 0; i < 32; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (writeEn && writeAddr != 5'd0)
		begin
			// register zero never takes a write
			regs[writeAddr] <= writeData;
		end
	end

	// combinational reads
	// no write-through here, forwarding sits in operandSelect
	always_comb
	begin
		if (readAddrA == 5'd0)
		begin
			readDataA = '0;
		end
		else
		begin
			readDataA = regs[readAddrA];
		end

		if (readAddrB == 5'd0)
		begin
			readDataB = '0;
		end
		else
		begin
			readDataB = regs[readAddrB];
		end
	end

endmodule

// File: tb.f
design/mipsPkg.sv
design/aluControl.sv
design/registerFile.sv
design/operandSelect.sv
design/alu.sv
design/executeCore.sv
bench/executeCore_properties.sv
bench/executeCoreTb.sv
